//--- src/gfx_pkg.sv
// geometry, ram widths, register numbers, interrupt bits, blitter states, ram request and rgb types
package gfx_pkg;

    // video ram
    localparam int VRAM_AW = 12;                // 4096 words

    typedef logic [15:0]        word_t;         // one ram word
    typedef logic [VRAM_AW-1:0] addr_t;         // one ram address

    // horizontal timing, in clocks
    localparam int H_VISIBLE   = 16;
    localparam int H_TOTAL     = 20;
    localparam int HSYNC_START = 17;            // hsync active high
    localparam int HSYNC_END   = 19;            // first pixel after sync
    localparam int H_CNT_W     = 5;             // holds 0..H_TOTAL-1

    // vertical timing, in lines
    localparam int V_VISIBLE  = 8;
    localparam int V_TOTAL    = 10;
    localparam int VSYNC_LINE = 9;
    localparam int V_CNT_W    = 4;              // holds 0..V_TOTAL-1

    localparam addr_t FB_BASE = '0;             // frame buffer start

    // cpu visible registers, 16 bits each
    typedef enum logic [3:0] {
        R_SYS_CTRL = 4'h0,                      // status / interrupt mask
        R_INTR     = 4'h1,                      // pending / clear
        R_RD_ADDR  = 4'h2,                      // read address, write prefetches
        R_WR_ADDR  = 4'h3,                      // write address
        R_DATA     = 4'h4,                      // vram data port
        R_BLIT_DST = 4'h5,
        R_BLIT_VAL = 4'h6,
        R_BLIT_CNT = 4'h7                       // write starts fill
    } reg_num_e;

    // interrupt bit positions
    localparam int INTR_VBLANK = 0;
    localparam int INTR_BLIT   = 1;

    typedef enum logic [1:0] {
        B_IDLE,
        B_RUN,
        B_DONE
    } blit_state_e;

    // one ram access, held with sel until ack
    typedef struct packed {
        logic  wr;                              // 1 = write
        addr_t addr;
        word_t data;                            // write data only
    } vram_req_t;

    // 12-bit output colour
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

//--- src/reg_interface.sv
// cpu byte bus decode, register file, auto-increment vram port with prefetch, blit and irq strobes
module reg_interface import gfx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,         // active low select
    input  logic        bus_rd_nwr_i,       // 1 = read
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,      // 0 = even (high) byte
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o,
    input  logic        vram_ack_i,
    input  word_t       vram_data_i,
    output logic        vram_sel_o,
    output vram_req_t   vram_req_o,
    input  logic        blit_busy_i,
    output addr_t       blit_dst_o,
    output word_t       blit_val_o,
    output addr_t       blit_cnt_o,
    output logic        blit_start_o,       // one cycle strobe
    input  logic [1:0]  intr_status_i,
    output logic [1:0]  intr_mask_o,
    output logic [1:0]  intr_clear_o        // one cycle strobe
);

logic [7:0] hi_byte;                        // even byte waiting for its odd half
word_t      wr_word;
logic       wr_stb;                         // odd byte write commits
logic       rd_stb;
reg_num_e   reg_num;
addr_t      rd_addr;
addr_t      wr_addr;
word_t      rd_buf;                         // prefetched word
logic       rd_pend;                        // prefetch not yet captured
logic       rd_cap;                         // read data on vram_data_i now
logic       rd_next;                        // odd byte read of R_DATA
logic       blit_ok;                        // blitter free to take a start
word_t      rd_word;

assign reg_num = reg_num_e'(bus_reg_num_i);
assign wr_stb  = ~bus_cs_n_i & ~bus_rd_nwr_i & bus_bytesel_i;
assign rd_stb  = ~bus_cs_n_i & bus_rd_nwr_i;
assign wr_word = {hi_byte, bus_data_i};
assign rd_next = rd_stb & bus_bytesel_i & (reg_num == R_DATA);
assign blit_ok = ~(blit_busy_i | blit_start_o);

// control state and strobes
always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o   <= 1'b0;
        rd_pend      <= 1'b0;
        rd_cap       <= 1'b0;
        blit_start_o <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        blit_start_o <= 1'b0;
        intr_clear_o <= '0;
        rd_cap       <= vram_ack_i & ~vram_req_o.wr;    // data valid next cycle
        if (vram_ack_i) begin
            vram_sel_o <= 1'b0;                     // access done
        end
        if (rd_cap) begin
            rd_pend <= 1'b0;
        end
        if (wr_stb) begin
            case (reg_num)
                R_SYS_CTRL: intr_mask_o  <= wr_word[1:0];
                R_INTR:     intr_clear_o <= wr_word[1:0];
                R_RD_ADDR: begin
                    vram_sel_o <= 1'b1;             // prefetch
                    rd_pend    <= 1'b1;
                end
                R_DATA:     vram_sel_o   <= 1'b1;   // store next cycle
                R_BLIT_CNT: blit_start_o <= blit_ok;
                default: ;
            endcase
        end
        if (rd_next) begin
            vram_sel_o <= 1'b1;                     // refetch at next address
            rd_pend    <= 1'b1;
        end
    end
end

// addresses, data and request payload
always_ff @(posedge clk) begin
    if (~bus_cs_n_i & ~bus_rd_nwr_i & ~bus_bytesel_i) begin
        hi_byte <= bus_data_i;
    end
    if (rd_cap) begin
        rd_buf <= vram_data_i;
    end
    if (wr_stb) begin
        case (reg_num)
            R_RD_ADDR: begin
                rd_addr         <= wr_word[VRAM_AW-1:0];
                vram_req_o.wr   <= 1'b0;
                vram_req_o.addr <= wr_word[VRAM_AW-1:0];
            end
            R_WR_ADDR: wr_addr <= wr_word[VRAM_AW-1:0];
            R_DATA: begin
                vram_req_o.wr   <= 1'b1;
                vram_req_o.addr <= wr_addr;
                vram_req_o.data <= wr_word;
                wr_addr         <= wr_addr + 1'b1;  // post increment
            end
            R_BLIT_DST: blit_dst_o <= wr_word[VRAM_AW-1:0];
            R_BLIT_VAL: blit_val_o <= wr_word;
            R_BLIT_CNT: begin
                if (blit_ok) begin
                    blit_cnt_o <= wr_word[VRAM_AW-1:0];
                end
            end
            default: ;
        endcase
    end
    if (rd_next) begin
        rd_addr         <= rd_addr + 1'b1;
        vram_req_o.wr   <= 1'b0;
        vram_req_o.addr <= rd_addr + 1'b1;
    end
end

// register readback mux
always_comb begin
    case (reg_num)
        // bit 0 covers any vram access in flight
        R_SYS_CTRL: rd_word = {14'b0, blit_busy_i, vram_sel_o | rd_pend};
        R_INTR:     rd_word = {14'b0, intr_status_i};
        R_RD_ADDR:  rd_word = word_t'(rd_addr);
        R_WR_ADDR:  rd_word = word_t'(wr_addr);
        R_DATA:     rd_word = rd_buf;
        R_BLIT_DST: rd_word = word_t'(blit_dst_o);
        R_BLIT_VAL: rd_word = blit_val_o;
        R_BLIT_CNT: rd_word = word_t'(blit_cnt_o);
        default:    rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (rd_stb) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];   // even = high half
    end
end

endmodule

//--- src/vram_arb.sv
// fixed priority vram arbiter (video, blitter, registers) and the single port ram array
module vram_arb import gfx_pkg::*; (
    input  logic      clk,
    input  logic      vid_sel_i,            // read only, never refused
    input  addr_t     vid_addr_i,
    input  logic      blit_sel_i,
    input  vram_req_t blit_req_i,
    input  logic      regs_sel_i,
    input  vram_req_t regs_req_i,
    output logic      blit_ack_o,
    output logic      regs_ack_o,
    output logic      vid_ack_o,
    output word_t     vram_data_o           // valid the cycle after a read ack
);

word_t     mem [2**VRAM_AW];
vram_req_t win;                             // granted access this cycle
logic      win_sel;

// one grant per cycle, video first
assign vid_ack_o  = vid_sel_i;
assign blit_ack_o = blit_sel_i & ~vid_sel_i;
assign regs_ack_o = regs_sel_i & ~vid_sel_i & ~blit_sel_i;
assign win_sel    = vid_sel_i | blit_sel_i | regs_sel_i;

always_comb begin
    win = regs_req_i;                       // lowest priority by default
    if (blit_sel_i) begin
        win = blit_req_i;
    end
    if (vid_sel_i) begin
        win.wr   = 1'b0;
        win.addr = vid_addr_i;
        win.data = '0;                      // unused on a read
    end
end

// write through the winner, registered read
always_ff @(posedge clk) begin
    if (win_sel) begin
        if (win.wr) begin
            mem[win.addr] <= win.data;
        end else begin
            vram_data_o <= mem[win.addr];
        end
    end
end

endmodule

//--- src/blitter.sv
// fill blitter: writes one constant word over a run of vram addresses, with busy and done
module blitter import gfx_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      start_i,              // ignored unless idle
    input  addr_t     dst_i,
    input  word_t     val_i,
    input  addr_t     cnt_i,                // words to write, 0 allowed
    input  logic      vram_ack_i,
    output logic      vram_sel_o,
    output vram_req_t vram_req_o,
    output logic      busy_o,
    output logic      done_o                // one cycle after the last write
);

blit_state_e state;
addr_t       addr_q;                        // next address to fill
word_t       val_q;
addr_t       cnt_q;                         // words still to write

// fsm
always_ff @(posedge clk) begin
    if (reset_i) begin
        state <= B_IDLE;
    end else begin
        case (state)
            B_IDLE: begin
                if (start_i) begin
                    state <= (cnt_i == '0) ? B_DONE : B_RUN;   // empty fill just finishes
                end
            end
            B_RUN: begin
                if (vram_ack_i && cnt_q == addr_t'(1)) begin
                    state <= B_DONE;        // last word written
                end
            end
            B_DONE:  state <= B_IDLE;
            default: state <= B_IDLE;
        endcase
    end
end

// run parameters
always_ff @(posedge clk) begin
    if (state == B_IDLE && start_i) begin
        addr_q <= dst_i;
        val_q  <= val_i;
        cnt_q  <= cnt_i;
    end else if (state == B_RUN && vram_ack_i) begin
        addr_q <= addr_q + 1'b1;
        cnt_q  <= cnt_q - 1'b1;
    end
end

assign vram_sel_o = (state == B_RUN);       // held until each ack
assign busy_o     = (state != B_IDLE);
assign done_o     = (state == B_DONE);

always_comb begin
    vram_req_o.wr   = 1'b1;                 // fill only writes
    vram_req_o.addr = addr_q;
    vram_req_o.data = val_q;
end

endmodule

//--- src/video_gen.sv
// video timing counters, sync and display enable, per pixel vram fetch and registered rgb out
module video_gen import gfx_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  vram_ack_i,
    input  word_t vram_data_i,
    output logic  vram_sel_o,               // one read per visible pixel
    output addr_t vram_addr_o,
    output rgb_t  rgb_o,
    output logic  hsync_o,
    output logic  vsync_o,
    output logic  dv_de_o,
    output logic  vblank_o                  // start of vertical blank pulse
);

logic [H_CNT_W-1:0] h_cnt;
logic [V_CNT_W-1:0] v_cnt;
logic               visible;
logic               hsync_c;
logic               vsync_c;
logic               hsync_d;                // delayed to match ram read
logic               vsync_d;
logic               de_d;
logic               fetch_d;                // ram data for this pixel arrives now

assign visible = (h_cnt < H_CNT_W'(H_VISIBLE)) && (v_cnt < V_CNT_W'(V_VISIBLE));
assign hsync_c = (h_cnt >= H_CNT_W'(HSYNC_START)) && (h_cnt < H_CNT_W'(HSYNC_END));
assign vsync_c = (v_cnt == V_CNT_W'(VSYNC_LINE));

// pixel address = base + y * width + x
assign vram_sel_o  = visible;
assign vram_addr_o = FB_BASE + addr_t'(v_cnt) * addr_t'(H_VISIBLE) + addr_t'(h_cnt);

// beam position
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt <= '0;
        v_cnt <= '0;
    end else if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
        h_cnt <= '0;
        if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
            v_cnt <= '0;                    // new frame
        end else begin
            v_cnt <= v_cnt + 1'b1;
        end
    end else begin
        h_cnt <= h_cnt + 1'b1;
    end
end

// two stage timing pipe: ram read, then output register
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_d  <= 1'b0;
        vsync_d  <= 1'b0;
        de_d     <= 1'b0;
        fetch_d  <= 1'b0;
        hsync_o  <= 1'b0;
        vsync_o  <= 1'b0;
        dv_de_o  <= 1'b0;
        vblank_o <= 1'b0;
    end else begin
        hsync_d  <= hsync_c;
        vsync_d  <= vsync_c;
        de_d     <= visible;
        fetch_d  <= vram_sel_o & vram_ack_i;
        hsync_o  <= hsync_d;
        vsync_o  <= vsync_d;
        dv_de_o  <= de_d;
        vblank_o <= (v_cnt == V_CNT_W'(V_VISIBLE)) && (h_cnt == '0);   // first blank line
    end
end

// pixel colour is the low 12 bits of the word, black in blanking
always_ff @(posedge clk) begin
    if (de_d && fetch_d) begin
        rgb_o <= rgb_t'(vram_data_i[11:0]);
    end else begin
        rgb_o <= '0;
    end
end

endmodule

//--- src/gfx_main.sv
// graphics controller top: register interface, blitter, video generator, vram arbiter, irq status
module gfx_main import gfx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,
    input  logic        bus_rd_nwr_i,
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o,
    output logic        bus_intr_o,         // one cycle interrupt pulse
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

// ram requesters
logic      regs_sel;
logic      regs_ack;
vram_req_t regs_req;
logic      blit_sel;
logic      blit_ack;
vram_req_t blit_req;
logic      vid_sel;
logic      vid_ack;
addr_t     vid_addr;
word_t     vram_data;                       // shared read data

// blitter control
addr_t     blit_dst;
word_t     blit_val;
addr_t     blit_cnt;
logic      blit_start;
logic      blit_busy;
logic      blit_done;

// interrupts
logic [1:0] intr_mask;
logic [1:0] intr_clear;
logic [1:0] intr_status;                    // pending bits
logic [1:0] intr_event;
logic       vblank;
rgb_t       rgb;

reg_interface u_regs (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .vram_ack_i(regs_ack), .vram_data_i(vram_data),
    .vram_sel_o(regs_sel), .vram_req_o(regs_req),
    .blit_busy_i(blit_busy), .blit_dst_o(blit_dst), .blit_val_o(blit_val),
    .blit_cnt_o(blit_cnt), .blit_start_o(blit_start),
    .intr_status_i(intr_status), .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
);

blitter u_blit (
    .clk(clk), .reset_i(reset_i),
    .start_i(blit_start), .dst_i(blit_dst), .val_i(blit_val), .cnt_i(blit_cnt),
    .vram_ack_i(blit_ack), .vram_sel_o(blit_sel), .vram_req_o(blit_req),
    .busy_o(blit_busy), .done_o(blit_done)
);

video_gen u_video (
    .clk(clk), .reset_i(reset_i),
    .vram_ack_i(vid_ack), .vram_data_i(vram_data),
    .vram_sel_o(vid_sel), .vram_addr_o(vid_addr),
    .rgb_o(rgb), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
    .vblank_o(vblank)
);

vram_arb u_arb (
    .clk(clk),
    .vid_sel_i(vid_sel), .vid_addr_i(vid_addr),
    .blit_sel_i(blit_sel), .blit_req_i(blit_req),
    .regs_sel_i(regs_sel), .regs_req_i(regs_req),
    .blit_ack_o(blit_ack), .regs_ack_o(regs_ack), .vid_ack_o(vid_ack),
    .vram_data_o(vram_data)
);

assign red_o   = rgb.red;
assign green_o = rgb.green;
assign blue_o  = rgb.blue;

assign intr_event[INTR_VBLANK] = vblank;
assign intr_event[INTR_BLIT]   = blit_done;

// pending status and cpu interrupt pulse
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_event & intr_mask & ~intr_status);  // only new, enabled events
        intr_status <= (intr_status & ~intr_clear) | intr_event;  // event wins over clear
    end
end

endmodule

//--- tb/clock_gen.sv
// testbench clock source and power-on reset pulse
module clock_gen (
    output logic clk_o,
    output logic reset_o
);
timeunit 1ns;
timeprecision 100ps;

localparam real HALF_PERIOD = 5.0;      // 10 ns clock

initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
end

// held over two rising edges, dropped just after the second
initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
end

endmodule

//--- tb/gfx_main_sva.sv
// concurrent checks on the vram arbiter handshake, the interrupt pulse and the reset state
module gfx_main_sva (
    input logic clk,
    input logic reset_i,
    input logic vid_sel_i,
    input logic vid_ack_i,
    input logic blit_sel_i,
    input logic blit_ack_i,
    input logic regs_sel_i,
    input logic regs_ack_i,
    input logic bus_intr_i,
    input logic hsync_i,
    input logic vsync_i,
    input logic dv_de_i
);
timeunit 1ns;
timeprecision 100ps;

int assert_fails = 0;                   // summed into the testbench error count

// arbiter grants a single requester
one_ack: assert property (@(posedge clk) $onehot0({vid_ack_i, blit_ack_i, regs_ack_i}))
    else begin
        assert_fails++;
        $error("more than one vram ack in one cycle");
    end

// no ack without a request behind it
ack_has_sel: assert property (@(posedge clk)
    (!vid_ack_i || vid_sel_i) && (!blit_ack_i || blit_sel_i) && (!regs_ack_i || regs_sel_i))
    else begin
        assert_fails++;
        $error("vram ack given to a unit whose sel is low");
    end

intr_single: assert property (@(posedge clk) disable iff (reset_i) bus_intr_i |=> !bus_intr_i)
    else begin
        assert_fails++;
        $error("bus_intr_o high for two cycles in a row");
    end

// video outputs come out of reset low
reset_quiet: assert property (@(posedge clk) reset_i |=> (!hsync_i && !vsync_i && !dv_de_i))
    else begin
        assert_fails++;
        $error("sync or display enable high in the cycle after reset");
    end

endmodule

//--- tb/gfx_main_tb.sv
// gfx_main testbench: byte bus driver, vram model, directed tests, frame capture, watchdog
module gfx_main_tb import gfx_pkg::*; ();
timeunit 1ns;
timeprecision 100ps;

localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
localparam int N_TESTS         = 5;
localparam int FRAMES_PER_TEST = 20;    // fills of the frame area take several frames
localparam int POLL_LIMIT      = 500;   // status reads before giving up
localparam longint WATCHDOG_NS = longint'(FRAME_CYCLES) * 10 * FRAMES_PER_TEST * N_TESTS + 2000;

logic       clk;
logic       reset;
logic       bus_cs_n;
logic       bus_rd_nwr;
logic [3:0] bus_reg_num;
logic       bus_bytesel;
logic [7:0] bus_data_w;
logic [7:0] bus_data_r;
logic       bus_intr;
logic [3:0] red;
logic [3:0] green;
logic [3:0] blue;
logic       hsync;
logic       vsync;
logic       dv_de;

int    seed = 5808;
int    errors = 0;
int    checks = 0;
int    tests_run = 0;
int    intr_pulses = 0;                 // bus_intr_o high cycles seen
word_t shadow [2**VRAM_AW];             // expected vram contents

clock_gen u_clk (.clk_o(clk), .reset_o(reset));

gfx_main uut (
    .clk(clk), .reset_i(reset),
    .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_data_w), .bus_data_o(bus_data_r),
    .bus_intr_o(bus_intr), .red_o(red), .green_o(green), .blue_o(blue),
    .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
);

bind gfx_main gfx_main_sva u_sva (
    .clk(clk), .reset_i(reset_i),
    .vid_sel_i(vid_sel), .vid_ack_i(vid_ack), .blit_sel_i(blit_sel), .blit_ack_i(blit_ack),
    .regs_sel_i(regs_sel), .regs_ack_i(regs_ack), .bus_intr_i(bus_intr_o),
    .hsync_i(hsync_o), .vsync_i(vsync_o), .dv_de_i(dv_de_o)
);

always @(posedge clk) begin
    if (bus_intr === 1'b1) begin
        intr_pulses++;                  // one per high cycle
    end
end

task automatic expect_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error: %s", what);
    end
endtask

// one bus cycle, driven just after the edge
task automatic bus_drive(input bit rd, input reg_num_e r, input bit bsel, input logic [7:0] d);
    @(posedge clk);
    #1;
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rd;
    bus_reg_num = r;
    bus_bytesel = bsel;
    bus_data_w  = d;
endtask

task automatic bus_release();
    @(posedge clk);
    #1;
    bus_cs_n = 1'b1;
endtask

task automatic bus_write16(input reg_num_e r, input word_t v);
    bus_drive(1'b0, r, 1'b0, v[15:8]);  // high byte latched first
    bus_drive(1'b0, r, 1'b1, v[7:0]);   // odd byte commits
    bus_release();
endtask

task automatic bus_read16(input reg_num_e r, output word_t v);
    bus_drive(1'b1, r, 1'b0, 8'h00);
    bus_drive(1'b1, r, 1'b1, 8'h00);
    v[15:8] = bus_data_r;               // even byte answer
    bus_release();
    v[7:0] = bus_data_r;
endtask

task automatic poll_status_clear(input int bit_idx);
    word_t s;
    int    n;
    n = 0;
    do begin
        bus_read16(R_SYS_CTRL, s);
        n++;
    end while (s[bit_idx] && n < POLL_LIMIT);
    expect_true(!s[bit_idx], "status bit stayed set while polling");
endtask

task automatic poll_intr_set(input int bit_idx);
    word_t s;
    int    n;
    n = 0;
    do begin
        bus_read16(R_INTR, s);
        n++;
    end while (!s[bit_idx] && n < POLL_LIMIT);
    expect_true(s[bit_idx], "pending interrupt bit never came up");
endtask

task automatic write_random_run(input addr_t base, input int n);
    word_t w;
    poll_status_clear(0);
    bus_write16(R_WR_ADDR, word_t'(base));
    for (int i = 0; i < n; i++) begin
        w = word_t'($random(seed));
        shadow[base + addr_t'(i)] = w;
        poll_status_clear(0);           // previous store must be taken
        bus_write16(R_DATA, w);
    end
endtask

task automatic check_run(input addr_t base, input int n);
    word_t got;
    poll_status_clear(0);
    bus_write16(R_RD_ADDR, word_t'(base));  // starts the prefetch
    for (int i = 0; i < n; i++) begin
        poll_status_clear(0);
        bus_read16(R_DATA, got);
        expect_word("R_DATA", got, shadow[base + addr_t'(i)]);
    end
endtask

task automatic test_reset();
    word_t v;
    expect_true(!bus_intr && !hsync && !vsync && !dv_de, "an output was high after reset");
    bus_read16(R_SYS_CTRL, v);
    expect_word("R_SYS_CTRL", v, 16'h0000);
    bus_read16(R_INTR, v);
    expect_word("R_INTR", v, 16'h0000);
endtask

task automatic test_blit();
    word_t v;
    word_t s;
    write_random_run(12'h1ff, 22);      // run plus one guard word each side
    bus_write16(R_SYS_CTRL, word_t'(1 << INTR_BLIT));
    v = word_t'($random(seed));
    bus_write16(R_BLIT_DST, 16'h0200);
    bus_write16(R_BLIT_VAL, v);
    intr_pulses = 0;
    bus_write16(R_BLIT_CNT, 16'd20);
    for (int i = 0; i < 20; i++) begin
        shadow[12'h200 + addr_t'(i)] = v;
    end
    poll_status_clear(1);               // busy
    repeat (3) @(posedge clk);
    expect_true(intr_pulses == 1, "blit done did not give exactly one interrupt pulse");
    bus_read16(R_INTR, s);
    expect_true(s[INTR_BLIT], "blit pending bit not set");
    check_run(12'h1ff, 22);
    bus_write16(R_INTR, word_t'(1 << INTR_BLIT));
    bus_write16(R_SYS_CTRL, 16'h0000);
    bus_read16(R_INTR, s);
    expect_word("R_INTR", s & word_t'(1 << INTR_BLIT), 16'h0000);  // vblank may be pending
endtask

// one frame from just after vblank, pixels counted in raster order
task automatic capture_frame();
    int    de_cycles;
    int    run;
    int    lines;
    int    vs_cycles;
    int    hs_cycles;
    addr_t a;
    de_cycles = 0;
    run = 0;
    lines = 0;
    vs_cycles = 0;
    hs_cycles = 0;
    for (int t = 0; t < FRAME_CYCLES; t++) begin
        @(posedge clk);
        #1;
        if (dv_de) begin
            a = FB_BASE + addr_t'((de_cycles / H_VISIBLE) * H_VISIBLE + de_cycles % H_VISIBLE);
            expect_word("rgb", word_t'({red, green, blue}), word_t'(shadow[a][11:0]));
            de_cycles++;
            run++;
        end else begin
            expect_word("rgb", word_t'({red, green, blue}), 16'h0000);   // black in blanking
            if (run != 0) begin
                expect_true(run == H_VISIBLE, "a display line had the wrong width");
                lines++;
                run = 0;
            end
        end
        vs_cycles += vsync;
        hs_cycles += hsync;
    end
    expect_true(de_cycles == H_VISIBLE * V_VISIBLE, "wrong number of enabled pixels");
    expect_true(lines == V_VISIBLE, "wrong number of display lines");
    expect_true(vs_cycles == H_TOTAL, "vsync was not high for exactly one line");
    expect_true(hs_cycles == (HSYNC_END - HSYNC_START) * V_TOTAL,
                "hsync was not high for the sync width on every line");
endtask

task automatic test_scanout();
    write_random_run(FB_BASE, H_VISIBLE * V_VISIBLE);
    poll_status_clear(0);
    bus_write16(R_INTR, word_t'(1 << INTR_VBLANK));
    poll_intr_set(INTR_VBLANK);
    capture_frame();
endtask

task automatic test_vblank_intr();
    bus_write16(R_SYS_CTRL, 16'h0000);
    bus_write16(R_INTR, word_t'(1 << INTR_VBLANK));
    intr_pulses = 0;
    poll_intr_set(INTR_VBLANK);
    repeat (2) @(posedge clk);
    expect_true(intr_pulses == 0, "masked vblank raised an interrupt");
    bus_write16(R_SYS_CTRL, word_t'(1 << INTR_VBLANK));
    bus_write16(R_INTR, word_t'(1 << INTR_VBLANK));
    intr_pulses = 0;
    poll_intr_set(INTR_VBLANK);
    repeat (2) @(posedge clk);
    expect_true(intr_pulses == 1, "enabled vblank did not give exactly one pulse");
    intr_pulses = 0;
    repeat (FRAME_CYCLES + H_TOTAL) @(posedge clk);   // next vblank, still pending
    expect_true(intr_pulses == 0, "vblank without a clear raised another interrupt");
    bus_write16(R_SYS_CTRL, 16'h0000);
endtask

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (errors == errors_before) ? "passed" : "FAILED");
endtask

initial begin
    int e0;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_data_w  = 8'h00;
    @(negedge reset);
    e0 = errors;
    test_reset();
    report_test("reset state", e0);
    e0 = errors;
    write_random_run(12'h100, 32);
    check_run(12'h100, 32);
    report_test("vram round trip", e0);
    e0 = errors;
    test_blit();
    report_test("blit fill", e0);
    e0 = errors;
    test_scanout();
    report_test("video scan-out", e0);
    e0 = errors;
    test_vblank_intr();
    report_test("vblank interrupt", e0);
    errors += uut.u_sva.assert_fails;
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

// watchdog, sized from the frame length and the test count
initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
end

endmodule

//--- filelist.f
src/gfx_pkg.sv
src/reg_interface.sv
src/vram_arb.sv
src/blitter.sv
src/video_gen.sv
src/gfx_main.sv
tb/clock_gen.sv
tb/gfx_main_sva.sv
tb/gfx_main_tb.sv
